/* rtl/goomba_pkg.sv */
`default_nettype none

package goomba_pkg;

    typedef logic [9:0]  coord_t;   // Screen coordinate
    typedef logic [23:0] color_t;   // RGB pixel

    typedef enum logic [2:0]
    {
        WALK_LEFT_A,
        WALK_LEFT_B,
        WALK_RIGHT_A,
        WALK_RIGHT_B,
        DYING,
        GONE
    } goomba_pose_e;

    // Playfield
    localparam coord_t X_MIN       = 10'd0;
    localparam coord_t X_MAX       = 10'd639;
    localparam coord_t X_START     = 10'd400;
    localparam coord_t GROUND_Y    = 10'd384;
    localparam coord_t SPRITE_SIZE = 10'd32;
    localparam coord_t X_STEP      = 10'd2;   // Per frame

    // Frame counts
    localparam int DECIDE_TICKS = 4;
    localparam int DEAD_TICKS   = 4;

    localparam int DECIDE_CNT_W = (DECIDE_TICKS > 1) ? $clog2(DECIDE_TICKS) : 1;
    localparam int DEAD_CNT_W   = (DEAD_TICKS > 1) ? $clog2(DEAD_TICKS) : 1;

    typedef logic [DECIDE_CNT_W-1:0] decide_cnt_t;
    typedef logic [DEAD_CNT_W-1:0]   dead_cnt_t;

    localparam decide_cnt_t DECIDE_LAST = decide_cnt_t'(DECIDE_TICKS - 1);
    localparam dead_cnt_t   DEAD_LAST   = dead_cnt_t'(DEAD_TICKS - 1);

endpackage

`default_nettype wire

/* rtl/goomba_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface goomba_if;

    import goomba_pkg::*;

    coord_t x;
    coord_t y;
    logic   phase_b;   // Second foot pose
    logic   dead;
    logic   gone;

    modport walker
    (
        output x,
        output y,
        output phase_b,
        output dead,
        output gone
    );

    // Hit test and sprite colour
    modport viewer
    (
        input x,
        input y,
        input phase_b,
        input dead,
        input gone
    );

endinterface

`default_nettype wire

/* rtl/goomba_tick_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module goomba_tick_timer
(
    input  logic Clk,
    input  logic reset,
    input  logic frame_clk,
    output logic tick,
    output logic decide
);

    import goomba_pkg::*;

    logic        frame_clk_d;
    logic        frame_rise;
    decide_cnt_t tick_cnt;

    assign frame_rise = frame_clk && !frame_clk_d;

    always_ff @(posedge Clk)
    begin
        frame_clk_d <= frame_clk;   // Previous frame clock level
    end

    always_ff @(posedge Clk)
    begin
        if (reset)
        begin
            tick     <= 1'b0;
            decide   <= 1'b0;
            tick_cnt <= '0;
        end
        else
        begin
            tick   <= frame_rise;
            decide <= frame_rise && (tick_cnt == DECIDE_LAST);
            if (frame_rise)
            begin
                tick_cnt <= (tick_cnt == DECIDE_LAST) ? '0 : tick_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/goomba_walker.sv */
`timescale 1ns/1ns
`default_nettype none

module goomba_walker
(
    input  logic              Clk,
    input  logic              reset,
    input  logic              tick,
    input  logic              decide,
    input  logic              alive,
    input  goomba_pkg::coord_t player_x,
    goomba_if.walker          state
);

    import goomba_pkg::*;

    goomba_pose_e pose;
    goomba_pose_e pose_next;
    coord_t       x_pos;
    coord_t       x_next;
    coord_t       y_pos;
    coord_t       y_next;
    dead_cnt_t    dead_cnt;
    dead_cnt_t    dead_cnt_next;

    logic facing_right;
    logic face_right;
    logic phase_b;
    logic phase_next;
    logic turn;

    assign facing_right = (pose == WALK_RIGHT_A) || (pose == WALK_RIGHT_B);
    assign phase_b      = (pose == WALK_LEFT_B) || (pose == WALK_RIGHT_B);

    always_comb
    begin
        pose_next     = pose;
        x_next        = x_pos;
        y_next        = y_pos;
        dead_cnt_next = dead_cnt;
        face_right    = facing_right;
        turn          = 1'b0;
        phase_next    = phase_b;

        if (tick)
        begin
            case (pose)
                WALK_LEFT_A, WALK_LEFT_B, WALK_RIGHT_A, WALK_RIGHT_B:
                begin
                    if (!alive)
                    begin
                        pose_next     = DYING;   // Stops where it stands
                        dead_cnt_next = '0;
                    end
                    else
                    begin
                        if (x_pos <= X_MIN)
                        begin
                            face_right = 1'b1;
                            turn       = 1'b1;
                        end
                        else if (x_pos + SPRITE_SIZE >= X_MAX)
                        begin
                            face_right = 1'b0;
                            turn       = 1'b1;
                        end
                        else if (decide)
                        begin
                            face_right = !(player_x < x_pos);   // Chase the player
                            turn       = 1'b1;
                        end

                        phase_next = phase_b ^ turn;
                        if (face_right)
                        begin
                            pose_next = phase_next ? WALK_RIGHT_B : WALK_RIGHT_A;
                            x_next    = x_pos + X_STEP;
                        end
                        else
                        begin
                            pose_next = phase_next ? WALK_LEFT_B : WALK_LEFT_A;
                            x_next    = x_pos - X_STEP;
                        end
                    end
                end

                DYING:
                begin
                    if (dead_cnt == DEAD_LAST)
                    begin
                        pose_next = GONE;
                        x_next    = '0;
                        y_next    = '0;
                    end
                    else
                    begin
                        dead_cnt_next = dead_cnt + 1'b1;
                    end
                end

                GONE:
                begin
                    x_next = '0;
                    y_next = '0;
                end

                default:
                begin
                    pose_next = GONE;   // Unused encodings
                end
            endcase
        end
    end

    always_ff @(posedge Clk)
    begin
        if (reset)
        begin
            pose     <= WALK_LEFT_A;
            x_pos    <= X_START;
            y_pos    <= GROUND_Y;
            dead_cnt <= '0;
        end
        else
        begin
            pose     <= pose_next;
            x_pos    <= x_next;
            y_pos    <= y_next;
            dead_cnt <= dead_cnt_next;
        end
    end

    assign state.x       = x_pos;
    assign state.y       = y_pos;
    assign state.phase_b = phase_b;
    assign state.dead    = (pose == DYING) || (pose == GONE);
    assign state.gone    = (pose == GONE);

endmodule

`default_nettype wire

/* rtl/goomba_hit_test.sv */
`timescale 1ns/1ns
`default_nettype none

module goomba_hit_test
(
    input  goomba_pkg::coord_t draw_x,
    input  goomba_pkg::coord_t draw_y,
    input  goomba_pkg::coord_t scroll_x,
    goomba_if.viewer           state,
    output logic               on_sprite
);

    import goomba_pkg::*;

    coord_t scan_x;    // Scan column in world space
    coord_t right_x;
    coord_t bottom_y;
    logic   in_cols;
    logic   in_rows;

    assign scan_x   = draw_x + scroll_x;
    assign right_x  = state.x + SPRITE_SIZE;
    assign bottom_y = state.y + SPRITE_SIZE;

    // Left edge exclusive, right edge inclusive
    assign in_cols = (state.x < scan_x) && (scan_x <= right_x);

    // Both rows exclusive
    assign in_rows = (draw_y > state.y) && (draw_y < bottom_y);

    assign on_sprite = in_cols && in_rows;

endmodule

`default_nettype wire

/* rtl/goomba_sprite_select.sv */
`timescale 1ns/1ns
`default_nettype none

module goomba_sprite_select
(
    input  logic               Clk,
    input  logic               reset,
    input  goomba_pkg::color_t color_a,
    input  goomba_pkg::color_t color_b,
    input  goomba_pkg::color_t color_dead,
    goomba_if.viewer           state,
    output goomba_pkg::color_t pixel
);

    import goomba_pkg::*;

    color_t pixel_next;

    always_comb
    begin
        if (state.gone)
        begin
            pixel_next = '0;   // Nothing drawn
        end
        else if (state.dead)
        begin
            pixel_next = color_dead;
        end
        else if (state.phase_b)
        begin
            pixel_next = color_b;
        end
        else
        begin
            pixel_next = color_a;
        end
    end

    always_ff @(posedge Clk)
    begin
        if (reset)
        begin
            pixel <= color_a;   // Left foot
        end
        else
        begin
            pixel <= pixel_next;
        end
    end

endmodule

`default_nettype wire

/* rtl/goomba_top.sv */
`timescale 1ns/1ns
`default_nettype none

module goomba_top
(
    input  logic               Clk,
    input  logic               reset,
    input  logic               frame_clk,
    input  logic               alive,
    input  goomba_pkg::coord_t player_x,
    input  goomba_pkg::coord_t draw_x,
    input  goomba_pkg::coord_t draw_y,
    input  goomba_pkg::coord_t scroll_x,
    input  goomba_pkg::color_t color_a,
    input  goomba_pkg::color_t color_b,
    input  goomba_pkg::color_t color_dead,
    output logic               on_sprite,
    output goomba_pkg::coord_t goomba_x,
    output goomba_pkg::coord_t goomba_y,
    output goomba_pkg::color_t pixel
);

    logic tick;
    logic decide;   // Only with tick

    goomba_if goomba_state ();

    goomba_tick_timer u_tick_timer
    (
        .Clk       (Clk),
        .reset     (reset),
        .frame_clk (frame_clk),
        .tick      (tick),
        .decide    (decide)
    );

    goomba_walker u_walker
    (
        .Clk      (Clk),
        .reset    (reset),
        .tick     (tick),
        .decide   (decide),
        .alive    (alive),
        .player_x (player_x),
        .state    (goomba_state.walker)
    );

    goomba_hit_test u_hit_test
    (
        .draw_x    (draw_x),
        .draw_y    (draw_y),
        .scroll_x  (scroll_x),
        .state     (goomba_state.viewer),
        .on_sprite (on_sprite)
    );

    goomba_sprite_select u_sprite_select
    (
        .Clk        (Clk),
        .reset      (reset),
        .color_a    (color_a),
        .color_b    (color_b),
        .color_dead (color_dead),
        .state      (goomba_state.viewer),
        .pixel      (pixel)
    );

    // Position for the game logic
    assign goomba_x = goomba_state.x;
    assign goomba_y = goomba_state.y;

endmodule

`default_nettype wire

/* include/goomba_tb_checks.svh */
`ifndef GOOMBA_TB_CHECKS_SVH
`define GOOMBA_TB_CHECKS_SVH

task automatic report_failure(input string reason);
    $display("%s", reason);
    $display("SOME TESTS FAILED");
    $fatal(1);
endtask

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    if (actual !== expected)
    begin
        report_failure($sformatf("mismatch at %0t ns: %s is %0h, expected %0h",
                                 $time, name, actual, expected));
    end
endtask

// Frame clock high for 3 cycles, low for 5
task automatic drive_frames(input int count);
    repeat (count)
    begin
        @(posedge Clk);
        #2;
        frame_clk = 1'b1;
        repeat (3) @(posedge Clk);
        #2;
        frame_clk = 1'b0;
        repeat (4) @(posedge Clk);
    end
    repeat (4) @(posedge Clk);   // Past tick, position and pixel stages
endtask

task automatic watch_for_hang(input int limit);
    repeat (limit) @(posedge Clk);
    report_failure($sformatf("timeout: run hung, no result after %0d cycles", limit));
endtask

`endif

/* test/goomba_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module goomba_tb;

    import goomba_pkg::*;

    localparam int REC_FIELDS  = 7;   // player_x alive frames x phase dead gone
    localparam int MAX_RECORDS = 32;

    logic   Clk = 1'b0;
    logic   reset;
    logic   frame_clk;
    logic   alive;
    coord_t player_x;
    coord_t draw_x;
    coord_t draw_y;
    coord_t scroll_x;
    color_t color_a;
    color_t color_b;
    color_t color_dead;
    logic   on_sprite;
    coord_t goomba_x;
    coord_t goomba_y;
    color_t pixel;

    logic [15:0] golden_mem [0:REC_FIELDS*MAX_RECORDS-1];
    int          watch_cycles = 0;

    `include "goomba_tb_checks.svh"

    goomba_top u_goomba_top
    (
        .Clk        (Clk),
        .reset      (reset),
        .frame_clk  (frame_clk),
        .alive      (alive),
        .player_x   (player_x),
        .draw_x     (draw_x),
        .draw_y     (draw_y),
        .scroll_x   (scroll_x),
        .color_a    (color_a),
        .color_b    (color_b),
        .color_dead (color_dead),
        .on_sprite  (on_sprite),
        .goomba_x   (goomba_x),
        .goomba_y   (goomba_y),
        .pixel      (pixel)
    );

    always #10 Clk = ~Clk;

    // Sprite box with zero scroll
    function automatic logic in_box(input coord_t gx, input coord_t gy,
                                    input coord_t sx, input coord_t sy);
        return (gx < sx) && (sx <= gx + SPRITE_SIZE) &&
               (sy > gy) && (sy < gy + SPRITE_SIZE);
    endfunction

    task automatic scan_checks(input coord_t gx, input coord_t gy);
        coord_t sx;
        coord_t sy;
        scroll_x = '0;
        draw_x   = gx + 10'd10;
        draw_y   = gy + 10'd10;
        #8;
        check_value("on_sprite", 32'(on_sprite), 32'd1);
        repeat (3)
        begin
            @(posedge Clk);
            #2;
            sx = coord_t'($urandom_range(639));
            sy = coord_t'($urandom_range(479));
            while (in_box(gx, gy, sx, sy))
            begin
                sx = coord_t'($urandom_range(639));
                sy = coord_t'($urandom_range(479));
            end
            draw_x = sx;
            draw_y = sy;
            #8;
            check_value("on_sprite", 32'(on_sprite), 32'd0);
        end
        @(posedge Clk);
        #2;
    endtask

    task automatic apply_record(input int rec);
        int     base;
        coord_t exp_x;
        coord_t exp_y;
        logic   exp_phase;
        logic   exp_dead;
        logic   exp_gone;
        color_t exp_pixel;
        base      = rec * REC_FIELDS;
        player_x  = golden_mem[base][9:0];
        alive     = golden_mem[base+1][0];
        exp_x     = golden_mem[base+3][9:0];
        exp_phase = golden_mem[base+4][0];
        exp_dead  = golden_mem[base+5][0];
        exp_gone  = golden_mem[base+6][0];
        drive_frames(int'(golden_mem[base+2]));
        #2;
        exp_y = exp_gone ? '0 : GROUND_Y;
        if (exp_gone)
            exp_pixel = '0;
        else if (exp_dead)
            exp_pixel = color_dead;
        else
            exp_pixel = exp_phase ? color_b : color_a;
        check_value("goomba_x", 32'(goomba_x), 32'(exp_x));
        check_value("goomba_y", 32'(goomba_y), 32'(exp_y));
        check_value("pixel", 32'(pixel), 32'(exp_pixel));
        if (!exp_gone)
            scan_checks(exp_x, exp_y);
    endtask

    initial
    begin
        wait (watch_cycles > 0);
        watch_for_hang(watch_cycles);
    end

    initial
    begin
        int i;
        int num_records;
        int total_frames;

        reset      = 1'b1;
        frame_clk  = 1'b0;
        alive      = 1'b1;
        player_x   = '0;
        draw_x     = '0;
        draw_y     = '0;
        scroll_x   = '0;
        color_a    = 24'hC06020;
        color_b    = 24'h8040A0;
        color_dead = 24'h505050;
        void'($urandom(16));

        for (i = 0; i < REC_FIELDS * MAX_RECORDS; i++)
        begin
            golden_mem[i] = 16'hFFFF;   // End marker
        end
        $readmemh("test/goomba_golden.txt", golden_mem);
        num_records  = 0;
        total_frames = 0;
        while (num_records < MAX_RECORDS &&
               golden_mem[num_records * REC_FIELDS] !== 16'hFFFF)
        begin
            total_frames += int'(golden_mem[num_records * REC_FIELDS + 2]);
            num_records++;
        end
        if (num_records == 0)
            report_failure("golden file test/goomba_golden.txt holds no records");
        watch_cycles = total_frames * 8 + 200;

        repeat (16) @(posedge Clk);
        #2;
        reset = 1'b0;
        @(posedge Clk);
        #2;
        check_value("goomba_x", 32'(goomba_x), 32'(X_START));
        check_value("goomba_y", 32'(goomba_y), 32'(GROUND_Y));
        check_value("pixel", 32'(pixel), 32'(color_a));
        scan_checks(X_START, GROUND_Y);

        for (i = 0; i < num_records; i++)
        begin
            apply_record(i);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* test/goomba_golden.txt */
// player_x alive frames exp_x phase dead gone, all in hex
// phase 0 is the first foot colour, 1 the second
// Player far right, turn toward it on every fourth frame
27F 1 1 18E 0 0 0
27F 1 2 18A 0 0 0
27F 1 1 18C 1 0 0
27F 1 3 192 1 0 0
27F 1 1 194 0 0 0
// Player held left, walk to the wall and bounce
000 1 4 198 1 0 0
000 1 C8 008 1 0 0
000 1 4 000 0 0 0
000 1 1 002 1 0 0
000 1 2 006 1 0 0
000 1 1 004 0 0 0
// Killed, dead image, then gone
000 0 1 004 0 1 0
000 0 3 004 0 1 0
000 0 1 000 0 1 1
000 1 2 000 0 1 1

/* files.f */
+incdir+include
rtl/goomba_pkg.sv
rtl/goomba_if.sv
rtl/goomba_tick_timer.sv
rtl/goomba_walker.sv
rtl/goomba_hit_test.sv
rtl/goomba_sprite_select.sv
rtl/goomba_top.sv
test/goomba_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = goomba_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
PASS_MSG  = ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
